// ==== hdl/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

////////////////////////////////////////
// instruction fields
////////////////////////////////////////
`define OP_FIELD    31:26
`define RS_FIELD    25:21
`define RT_FIELD    20:16
`define RD_FIELD    15:11
`define FUNCT_FIELD 5:0

////////////////////////////////////////
// primary opcodes
////////////////////////////////////////
`define OP_SPECIAL 6'b000000 // funct decides
`define OP_REGIMM  6'b000001 // rt decides
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111
`define OP_ADDI    6'b001000
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_LB      6'b100000
`define OP_LH      6'b100001
`define OP_LW      6'b100011
`define OP_LBU     6'b100100
`define OP_LHU     6'b100101
`define OP_SB      6'b101000
`define OP_SH      6'b101001
`define OP_SW      6'b101011

////////////////////////////////////////
// SPECIAL funct codes
////////////////////////////////////////
`define FN_SLL  6'b000000 // all-zero word is the nop
`define FN_SRL  6'b000010
`define FN_SRA  6'b000011
`define FN_SLLV 6'b000100
`define FN_SRLV 6'b000110
`define FN_SRAV 6'b000111
`define FN_JR   6'b001000
`define FN_JALR 6'b001001
`define FN_ADD  6'b100000
`define FN_ADDU 6'b100001
`define FN_SUB  6'b100010
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

// REGIMM sub-codes in rt
`define RT_BLTZ 5'b00000
`define RT_BGEZ 5'b00001

`define TUSE_NONE 2'd3  // operand never read
`define RA_REG    5'd31 // link register for jal

`endif

// ==== hdl/decode_pkg.sv ====
package decode_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  regAddr_t;

  ////////////////////////////////////////
  // decode codes
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    CAL_R, SHIFT_IMM, CAL_I, BRANCH, LOAD, STORE,
    JAL, J, JR, JALR, ILLEGAL
  } instrClass_e;

  typedef enum logic [3:0] {
    ALU_AND  = 4'd0,
    ALU_OR   = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_NOR  = 4'd5,
    ALU_SLT  = 4'd6,
    ALU_SLTU = 4'd7,
    ALU_SLL  = 4'd8,
    ALU_SRL  = 4'd9,
    ALU_SRA  = 4'd10
  } aluOp_e;

  typedef enum logic [2:0] {BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ} branchOp_e;
  typedef enum logic [2:0] {LD_B, LD_BU, LD_H, LD_HU, LD_W} loadSel_e;
  typedef enum logic [1:0] {ST_B, ST_H, ST_W} storeSel_e;
  typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_LUI} extOp_e;
  typedef enum logic [1:0] {WD_PC8, WD_ALU, WD_MEM} wdSel_e; // each stage picks its own source
  typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_REG, NPC_JUMP} npcSrc_e;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////
  typedef struct packed {
    aluOp_e    aluOp;
    branchOp_e branchOp;
    loadSel_e  loadSel;
    storeSel_e storeSel;
    extOp_e    extOp;
  } subOps_t; // 14 bits

  typedef struct packed {
    logic      regWrite;
    logic      memWrite;
    logic      aluASrc;  // shamt as operand A
    logic      aluBSrc;  // immediate as operand B
    wdSel_e    wdSel;
    regAddr_t  wba;
    extOp_e    extOp;
    aluOp_e    aluOp;
    branchOp_e branchOp;
    loadSel_e  loadSel;
    storeSel_e storeSel;
    npcSrc_e   npcSrc;
    logic      exist;
  } ctrlWord_t; // 28 bits

  typedef struct packed {
    logic [1:0] tuseRs;
    logic [1:0] tuseRt;
    logic [1:0] tnewE;
    logic [1:0] tnewM;
  } stageTiming_t;

  typedef struct packed {
    ctrlWord_t    ctrl;
    stageTiming_t timing;
  } decodeOut_t; // 36 bits

endpackage

// ==== hdl/pipeReg.sv ====
module pipeReg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     inValid,
  output logic     inReady,
  input  payload_t inData,
  output logic     outValid,
  input  logic     outReady,
  output payload_t outData
);

  logic     full;
  payload_t data;

  // open when empty or when the held item leaves this cycle
  assign inReady = !full || outReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (inReady) begin
      full <= inValid; // refill or drain
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      data <= inData;
    end
  end

  assign outValid = full;
  assign outData  = data;

endmodule

// ==== hdl/opDecoder.sv ====
`include "mips_consts.svh"

module opDecoder (
  input  decode_pkg::instr_t      instr,
  output decode_pkg::instrClass_e iClass,
  output decode_pkg::subOps_t     subOps
);
  import decode_pkg::*;

  logic [5:0] op;
  logic [5:0] funct;
  regAddr_t   rtSub;

  assign op    = instr[`OP_FIELD];
  assign funct = instr[`FUNCT_FIELD];
  assign rtSub = instr[`RT_FIELD]; // REGIMM selector

  always_comb begin
    iClass = ILLEGAL;
    subOps = '0; // unused fields stay zero
    case (op)
      ////////////////////////////////////////
      // SPECIAL
      ////////////////////////////////////////
      `OP_SPECIAL: begin
        iClass = CAL_R;
        case (funct)
          `FN_ADD, `FN_ADDU: subOps.aluOp = ALU_ADD;
          `FN_SUB, `FN_SUBU: subOps.aluOp = ALU_SUB;
          `FN_AND:  subOps.aluOp = ALU_AND;
          `FN_OR:   subOps.aluOp = ALU_OR;
          `FN_XOR:  subOps.aluOp = ALU_XOR;
          `FN_NOR:  subOps.aluOp = ALU_NOR;
          `FN_SLT:  subOps.aluOp = ALU_SLT;
          `FN_SLTU: subOps.aluOp = ALU_SLTU;
          `FN_SLLV: subOps.aluOp = ALU_SLL;
          `FN_SRLV: subOps.aluOp = ALU_SRL;
          `FN_SRAV: subOps.aluOp = ALU_SRA;
          `FN_SLL, `FN_SRL, `FN_SRA: begin
            iClass = SHIFT_IMM;
            subOps.aluOp = (funct == `FN_SLL) ? ALU_SLL :
                           (funct == `FN_SRL) ? ALU_SRL : ALU_SRA;
          end
          `FN_JR:   iClass = JR;
          `FN_JALR: iClass = JALR;
          default:  iClass = ILLEGAL; // mult/div and the rest
        endcase
      end

      ////////////////////////////////////////
      // immediate ALU
      ////////////////////////////////////////
      `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU: begin
        iClass = CAL_I;
        subOps.extOp = EXT_SIGN;
        subOps.aluOp = (op == `OP_SLTI)  ? ALU_SLT :
                       (op == `OP_SLTIU) ? ALU_SLTU : ALU_ADD;
      end
      `OP_ANDI, `OP_ORI, `OP_XORI: begin
        iClass = CAL_I;
        subOps.extOp = EXT_ZERO;
        subOps.aluOp = (op == `OP_ANDI) ? ALU_AND :
                       (op == `OP_ORI)  ? ALU_OR : ALU_XOR;
      end
      `OP_LUI: begin
        iClass = CAL_I;
        subOps.extOp = EXT_LUI; // shifted imm plus zero
        subOps.aluOp = ALU_ADD;
      end

      ////////////////////////////////////////
      // branches
      ////////////////////////////////////////
      `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
        iClass = BRANCH;
        subOps.extOp = EXT_SIGN;
        subOps.branchOp = branchOp_e'(op[1:0]); // eq, ne, lez, gtz in order
      end
      `OP_REGIMM: begin
        if (rtSub == `RT_BLTZ || rtSub == `RT_BGEZ) begin
          iClass = BRANCH;
          subOps.extOp = EXT_SIGN;
          subOps.branchOp = (rtSub == `RT_BLTZ) ? BR_LTZ : BR_GEZ;
        end
      end

      ////////////////////////////////////////
      // memory
      ////////////////////////////////////////
      `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW: begin
        iClass = LOAD;
        subOps.extOp = EXT_SIGN;
        subOps.aluOp = ALU_ADD; // base plus offset
        subOps.loadSel = (op == `OP_LB)  ? LD_B  :
                         (op == `OP_LBU) ? LD_BU :
                         (op == `OP_LH)  ? LD_H  :
                         (op == `OP_LHU) ? LD_HU : LD_W;
      end
      `OP_SB, `OP_SH, `OP_SW: begin
        iClass = STORE;
        subOps.extOp = EXT_SIGN;
        subOps.aluOp = ALU_ADD;
        subOps.storeSel = (op == `OP_SB) ? ST_B :
                          (op == `OP_SH) ? ST_H : ST_W;
      end

      `OP_J:   iClass = J;
      `OP_JAL: iClass = JAL;
      default: iClass = ILLEGAL; // cop0 and unused opcodes
    endcase
  end

endmodule

// ==== hdl/ctrlFieldGen.sv ====
`include "mips_consts.svh"

module ctrlFieldGen (
  input  decode_pkg::instrClass_e iClass,
  input  decode_pkg::subOps_t     subOps,
  input  decode_pkg::instr_t      instr,
  output decode_pkg::ctrlWord_t   ctrl
);
  import decode_pkg::*;

  regAddr_t rd;
  regAddr_t rt;

  assign rd = instr[`RD_FIELD];
  assign rt = instr[`RT_FIELD];

  always_comb begin
    ctrl = '0; // non-writers keep wdSel and wba at zero
    ctrl.extOp    = subOps.extOp;
    ctrl.aluOp    = subOps.aluOp;
    ctrl.branchOp = subOps.branchOp;
    ctrl.loadSel  = subOps.loadSel;
    ctrl.storeSel = subOps.storeSel;
    ctrl.exist    = (iClass != ILLEGAL);

    case (iClass)
      CAL_R: begin
        ctrl.regWrite = 1'b1;
        ctrl.wdSel    = WD_ALU;
        ctrl.wba      = rd;
      end
      SHIFT_IMM: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluASrc  = 1'b1; // shamt in place of rs
        ctrl.wdSel    = WD_ALU;
        ctrl.wba      = rd;
      end
      CAL_I: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluBSrc  = 1'b1;
        ctrl.wdSel    = WD_ALU;
        ctrl.wba      = rt;
      end
      LOAD: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluBSrc  = 1'b1;
        ctrl.wdSel    = WD_MEM;
        ctrl.wba      = rt;
      end
      STORE: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluBSrc  = 1'b1;
      end
      BRANCH: ctrl.npcSrc = NPC_BRANCH;
      J:      ctrl.npcSrc = NPC_JUMP;
      JR:     ctrl.npcSrc = NPC_REG;
      JAL: begin
        ctrl.regWrite = 1'b1;
        ctrl.wdSel    = WD_PC8;
        ctrl.wba      = `RA_REG;
        ctrl.npcSrc   = NPC_JUMP;
      end
      JALR: begin
        ctrl.regWrite = 1'b1;
        ctrl.wdSel    = WD_PC8;
        ctrl.wba      = rd;
        ctrl.npcSrc   = NPC_REG;
      end
      default: ctrl.npcSrc = NPC_SEQ; // illegal, all inactive
    endcase
  end

endmodule

// ==== hdl/hazardTiming.sv ====
`include "mips_consts.svh"

module hazardTiming (
  input  decode_pkg::instrClass_e  iClass,
  output decode_pkg::stageTiming_t timing
);
  import decode_pkg::*;

  // tuse counts cycles from decode until the operand is read,
  // tnew counts cycles until the result can be forwarded
  always_comb begin
    timing.tuseRs = `TUSE_NONE;
    timing.tuseRt = `TUSE_NONE;
    timing.tnewE  = 2'd0;
    timing.tnewM  = 2'd0;
    case (iClass)
      CAL_R: begin
        timing.tuseRs = 2'd1;
        timing.tuseRt = 2'd1;
        timing.tnewE  = 2'd1;
      end
      SHIFT_IMM: begin
        timing.tuseRt = 2'd1;
        timing.tnewE  = 2'd1;
      end
      CAL_I: begin
        timing.tuseRs = 2'd1;
        timing.tnewE  = 2'd1;
      end
      BRANCH: begin
        timing.tuseRs = 2'd0; // compared in decode
        timing.tuseRt = 2'd0;
      end
      LOAD: begin
        timing.tuseRs = 2'd1;
        timing.tnewE  = 2'd2;
        timing.tnewM  = 2'd1; // data back after mem
      end
      STORE: begin
        timing.tuseRs = 2'd1;
        timing.tuseRt = 2'd2; // needed only in mem
      end
      JR, JALR: timing.tuseRs = 2'd0;
      default: timing.tnewE = 2'd0; // jal, j, illegal; pc+8 is ready at once
    endcase
  end

endmodule

// ==== hdl/decodeUnit.sv ====
module decodeUnit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inValid,
  output logic                   inReady,
  input  decode_pkg::instr_t     inInstr,
  output logic                   outValid,
  input  logic                   outReady,
  output decode_pkg::decodeOut_t outData
);
  import decode_pkg::*;

  logic         instrValid;
  logic         instrReady;
  instr_t       instrQ;
  instrClass_e  iClass;
  subOps_t      subOps;
  ctrlWord_t    ctrl;
  stageTiming_t timing;
  decodeOut_t   decoded;

  ////////////////////////////////////////
  // stage 1 instruction slice
  ////////////////////////////////////////
  pipeReg #(.payload_t(instr_t)) instrStage (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inData   (inInstr),
    .outValid (instrValid),
    .outReady (instrReady), // from the output slice
    .outData  (instrQ)
  );

  // combinational decode between slices
  opDecoder decoder (
    .instr  (instrQ),
    .iClass (iClass),
    .subOps (subOps)
  );

  ctrlFieldGen ctrlGen (
    .iClass (iClass),
    .subOps (subOps),
    .instr  (instrQ),
    .ctrl   (ctrl)
  );

  hazardTiming timingGen (
    .iClass (iClass),
    .timing (timing)
  );

  assign decoded = '{ctrl: ctrl, timing: timing};

  ////////////////////////////////////////
  // stage 2 result slice
  ////////////////////////////////////////
  pipeReg #(.payload_t(decodeOut_t)) outStage (
    .clk      (clk),
    .rst      (rst),
    .inValid  (instrValid),
    .inReady  (instrReady),
    .inData   (decoded),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
  );

endmodule

// ==== bench/decodeUnit_props.sv ====
module decodeUnit_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   inReady,
  input logic                   outValid,
  input logic                   outReady,
  input decode_pkg::decodeOut_t outData
);

  int failures = 0; // read by the testbench

  resetEmpty: assert property (@(posedge clk) rst |=> !outValid && inReady)
    else begin
      failures++;
      $error("slices not empty after reset");
    end

  holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
      outValid && !outReady |=> outValid && $stable(outData))
    else begin
      failures++;
      $error("outData changed or dropped while stalled");
    end

endmodule

bind decodeUnit decodeUnit_props props (
  .clk      (clk),
  .rst      (rst),
  .inReady  (inReady),
  .outValid (outValid),
  .outReady (outReady),
  .outData  (outData)
);

// ==== bench/decodeUnit_tb.sv ====
module decodeUnit_tb;
  import decode_pkg::*;

  logic       clk;
  logic       rst;
  logic       inValid;
  logic       inReady;
  instr_t     inInstr;
  logic       outValid;
  logic       outReady;
  decodeOut_t outData;

  instr_t     caseInstr[$];
  decodeOut_t caseExp[$];
  decodeOut_t expQ[$];      // accepted, not yet seen at the output
  logic [15:0] lfsr = 16'd14;
  int         cycles = 0;
  int         cycleLimit;

  decodeUnit DUT (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inInstr  (inInstr),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic abortRun(input string why);
    $display("Errors found");
    $fatal(1, "%s", why);
  endtask

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic takeRandomBit(output logic b);
    lfsr = lfsrNext(lfsr);
    b = lfsr[0];
  endtask

  task automatic checkCtrl(input ctrlWord_t got, input ctrlWord_t exp);
    if (got !== exp) begin
      $display("Error at %0t: outData.ctrl = %h, expected %h", $time, got, exp);
      abortRun("control word mismatch");
    end
  endtask

  task automatic checkTiming(input stageTiming_t got, input stageTiming_t exp);
    if (got !== exp) begin
      $display("Error at %0t: outData.timing = %h, expected %h", $time, got, exp);
      abortRun("hazard timing mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      abortRun("handshake signal mismatch");
    end
  endtask

  // one case per line, 18 hex columns, # starts a comment line
  task automatic readCases();
    int         fd;
    int         n;
    string      line;
    logic [31:0] f [18];
    decodeOut_t exp;
    fd = $fopen("bench/decode_cases.txt", "r");
    if (fd == 0) begin
      abortRun("cannot open bench/decode_cases.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                      f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
          if (n != 18) begin
            abortRun("malformed line in the case file");
          end else begin
            exp.ctrl.regWrite = f[1][0];
            exp.ctrl.memWrite = f[2][0];
            exp.ctrl.aluASrc  = f[3][0];
            exp.ctrl.aluBSrc  = f[4][0];
            exp.ctrl.wdSel    = wdSel_e'(f[5][1:0]);
            exp.ctrl.wba      = f[6][4:0];
            exp.ctrl.extOp    = extOp_e'(f[7][1:0]);
            exp.ctrl.aluOp    = aluOp_e'(f[8][3:0]);
            exp.ctrl.branchOp = branchOp_e'(f[9][2:0]);
            exp.ctrl.loadSel  = loadSel_e'(f[10][2:0]);
            exp.ctrl.storeSel = storeSel_e'(f[11][1:0]);
            exp.ctrl.npcSrc   = npcSrc_e'(f[12][1:0]);
            exp.ctrl.exist    = f[13][0];
            exp.timing.tuseRs = f[14][1:0];
            exp.timing.tuseRt = f[15][1:0];
            exp.timing.tnewE  = f[16][1:0];
            exp.timing.tnewM  = f[17][1:0];
            caseInstr.push_back(f[0]);
            caseExp.push_back(exp);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // case runner
  ////////////////////////////////////////
  // stream mode holds inValid and outReady high, otherwise the lfsr picks both
  task automatic runCases(input logic stream);
    int         sent;
    int         got;
    int         cyc;
    logic       pending;
    logic       b;
    decodeOut_t exp;
    sent = 0;
    got = 0;
    cyc = 0;
    pending = 1'b0;
    while (got < caseInstr.size()) begin
      @(negedge clk);
      if (!pending) begin // an offer is held until it transfers
        if (stream) b = 1'b1;
        else takeRandomBit(b);
        if (b && sent < caseInstr.size()) begin
          inValid = 1'b1;
          inInstr = caseInstr[sent];
          pending = 1'b1;
        end else begin
          inValid = 1'b0;
        end
      end
      if (stream) b = 1'b1;
      else takeRandomBit(b);
      outReady = b;
      #1; // sample what the next rising edge will see
      if (inValid && inReady) begin
        expQ.push_back(caseExp[sent]);
        sent++;
        pending = 1'b0;
      end
      if (outValid && outReady) begin
        if (expQ.size() == 0) begin
          abortRun("output transfer with no instruction outstanding");
        end else begin
          exp = expQ.pop_front();
          checkCtrl(outData.ctrl, exp.ctrl);
          checkTiming(outData.timing, exp.timing);
          got++;
        end
      end
      if (stream && cyc >= 2) checkBit("outValid", outValid, 1'b1); // two in flight
      cyc++;
    end
  endtask

  initial begin
    rst = 1'b1;
    inValid = 1'b0;
    inInstr = '0;
    outReady = 1'b0;
    readCases();
    cycleLimit = 8 * caseInstr.size() + 50;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    #1;
    checkBit("outValid", outValid, 1'b0);
    checkBit("inReady", inReady, 1'b1);

    runCases(1'b0); // random gaps and back-pressure
    runCases(1'b1); // back to back

    // nothing may come out after the last case
    repeat (3) begin
      @(negedge clk);
      outReady = 1'b1;
      #1;
      checkBit("outValid", outValid, 1'b0);
    end

    if (expQ.size() != 0 || DUT.props.failures != 0) begin
      $display("results left unchecked or a bound assertion failed");
      abortRun("run ended with failures");
    end else begin
      $display("No errors");
      $finish;
    end
  end

  // watchdog, also picks up failures of the bound assertions
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycleLimit) begin
      $display("timeout: run passed %0d cycles", cycleLimit);
      abortRun("timeout");
    end else if (DUT.props.failures != 0) begin
      $display("a bound assertion on decodeUnit failed");
      abortRun("assertion failure");
    end
  end

endmodule

// ==== bench/decode_cases.txt ====
# instr regWrite memWrite aluASrc aluBSrc wdSel wba extOp aluOp branchOp loadSel storeSel npcSrc
#   exist tuseRs tuseRt tnewE tnewM, all hex, enum fields as their numeric codes
# nop and register ALU
00000000 1 0 1 0 1 00 0 8 0 0 0 0 1 3 1 1 0
00221820 1 0 0 0 1 03 0 2 0 0 0 0 1 1 1 1 0
00221822 1 0 0 0 1 03 0 3 0 0 0 0 1 1 1 1 0
00221827 1 0 0 0 1 03 0 5 0 0 0 0 1 1 1 1 0
0022182b 1 0 0 0 1 03 0 7 0 0 0 0 1 1 1 1 0
00221807 1 0 0 0 1 03 0 a 0 0 0 0 1 1 1 1 0
00022142 1 0 1 0 1 04 0 9 0 0 0 0 1 3 1 1 0
00022043 1 0 1 0 1 04 0 a 0 0 0 0 1 3 1 1 0
# immediate ALU and lui
24220010 1 0 0 1 1 02 1 2 0 0 0 0 1 1 3 1 0
3022ffff 1 0 0 1 1 02 0 0 0 0 0 0 1 1 3 1 0
34220001 1 0 0 1 1 02 0 1 0 0 0 0 1 1 3 1 0
2822fff0 1 0 0 1 1 02 1 6 0 0 0 0 1 1 3 1 0
3c021234 1 0 0 1 1 02 2 2 0 0 0 0 1 1 3 1 0
# branches
10220004 0 0 0 0 0 00 1 0 0 0 0 1 1 0 0 0 0
1422fffc 0 0 0 0 0 00 1 0 1 0 0 1 1 0 0 0 0
18200008 0 0 0 0 0 00 1 0 2 0 0 1 1 0 0 0 0
1c200008 0 0 0 0 0 00 1 0 3 0 0 1 1 0 0 0 0
04200010 0 0 0 0 0 00 1 0 4 0 0 1 1 0 0 0 0
04210010 0 0 0 0 0 00 1 0 5 0 0 1 1 0 0 0 0
# loads and stores
80280004 1 0 0 1 2 08 1 2 0 0 0 0 1 1 3 2 1
90280004 1 0 0 1 2 08 1 2 0 1 0 0 1 1 3 2 1
84280002 1 0 0 1 2 08 1 2 0 2 0 0 1 1 3 2 1
94280002 1 0 0 1 2 08 1 2 0 3 0 0 1 1 3 2 1
8c280000 1 0 0 1 2 08 1 2 0 4 0 0 1 1 3 2 1
a0280004 0 1 0 1 0 00 1 2 0 0 0 0 1 1 2 0 0
a4280002 0 1 0 1 0 00 1 2 0 0 1 0 1 1 2 0 0
ac280000 0 1 0 1 0 00 1 2 0 0 2 0 1 1 2 0 0
# jumps
08000100 0 0 0 0 0 00 0 0 0 0 0 3 1 3 3 0 0
0c000100 1 0 0 0 0 1f 0 0 0 0 0 3 1 3 3 0 0
03e00008 0 0 0 0 0 00 0 0 0 0 0 2 1 0 3 0 0
00201809 1 0 0 0 0 03 0 0 0 0 0 2 1 0 3 0 0
# mult, mfc0 and an unused opcode
00220018 0 0 0 0 0 00 0 0 0 0 0 0 0 3 3 0 0
40026000 0 0 0 0 0 00 0 0 0 0 0 0 0 3 3 0 0
fc221234 0 0 0 0 0 00 0 0 0 0 0 0 0 3 3 0 0

// ==== compile.f ====
+incdir+hdl
hdl/decode_pkg.sv
hdl/pipeReg.sv
hdl/opDecoder.sv
hdl/ctrlFieldGen.sv
hdl/hazardTiming.sv
hdl/decodeUnit.sv
bench/decodeUnit_props.sv
bench/decodeUnit_tb.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = decodeUnit_tb
FILELIST  = compile.f
RUN_FLAGS = +verilator+error+limit+100
BUILD_DIR = obj_dir
BIN       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "No errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
